/* hw/uart_pkg.sv */
// UART receive definitions
package uart_pkg;

    // Bit timing, in clock cycles.
    localparam int BIT_CLKS = 16;
    localparam int HALF_BIT = 8;   // Start edge to start-bit center.

    // Frame layout.
    localparam int DATA_BITS = 8;

    // Receiver counter widths.
    localparam int CNT_W = $clog2(BIT_CLKS);
    localparam int IDX_W = $clog2(DATA_BITS);

    // Receive FIFO geometry.
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_AW    = 2;

    // One FIFO entry holds the byte plus parity and frame error flags.
    localparam int ENTRY_W = DATA_BITS + 2;

    // Frame receiver states.
    // RX_START waits half a bit and re-checks the line, so short
    // glitches never reach the data phase.
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_t;

endpackage

/* hw/rx_line_sync.sv */
// Serial line synchronizer
module rx_line_sync (
    input  logic clk,
    input  logic nRst,
    input  logic rx_serial,
    output logic rx_sync,
    output logic start_edge
);

    logic sync_meta;
    logic sync_line;
    logic sync_prev;

    // The idle line is high, so every stage resets to 1.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            sync_meta <= 1'b1;
            sync_line <= 1'b1;
            sync_prev <= 1'b1;
        end else begin
            sync_meta <= rx_serial;
            sync_line <= sync_meta;
            sync_prev <= sync_line;   // One cycle older copy for edge detection.
        end
    end

    // Registered high-to-low transition of the synchronized line.
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            start_edge <= 1'b0;
        end else begin
            start_edge <= sync_prev & ~sync_line;
        end
    end

    assign rx_sync = sync_line;

endmodule

/* hw/uart_rx.sv */
// UART frame receiver
module uart_rx (
    input  logic                       clk,
    input  logic                       nRst,
    input  logic                       rx_sync,
    input  logic                       start_edge,
    output logic                       frame_valid,
    output logic [uart_pkg::DATA_BITS-1:0] frame_data,
    output logic                       frame_parity,
    output logic                       frame_stop
);

    import uart_pkg::*;

    rx_state_t        state;
    rx_state_t        state_next;
    logic [CNT_W-1:0] cnt;
    logic [IDX_W-1:0] bit_idx;
    logic             half_done;
    logic             bit_done;
    logic             last_data;

    assign half_done = (cnt == CNT_W'(HALF_BIT - 1));
    assign bit_done  = (cnt == CNT_W'(BIT_CLKS - 1));
    assign last_data = (bit_idx == IDX_W'(DATA_BITS - 1));

    always_comb begin
        state_next = state;
        case (state)
            RX_IDLE: begin
                if (start_edge) begin
                    state_next = RX_START;
                end
            end
            RX_START: begin
                // A line that is high again at mid start bit was only a glitch.
                if (half_done) begin
                    state_next = rx_sync ? RX_IDLE : RX_DATA;
                end
            end
            RX_DATA: begin
                if (bit_done && last_data) begin
                    state_next = RX_PARITY;
                end
            end
            RX_PARITY: begin
                if (bit_done) begin
                    state_next = RX_STOP;
                end
            end
            RX_STOP: begin
                if (bit_done) begin
                    state_next = RX_IDLE;
                end
            end
            default: begin
                state_next = RX_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state       <= RX_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            frame_valid <= 1'b0;
        end else begin
            state <= state_next;

            // The counter restarts on every state change and at each bit boundary.
            if (state == RX_IDLE || state_next != state || bit_done) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end

            if (state == RX_IDLE) begin
                bit_idx <= '0;
            end else if (state == RX_DATA && bit_done) begin
                bit_idx <= bit_idx + 1'b1;
            end

            // Pulses in the cycle after the stop sample, with the machine back in idle.
            frame_valid <= (state == RX_STOP) && bit_done;
        end
    end

    // Sampled frame fields, each captured at its bit center.
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_done) begin
            frame_data <= {rx_sync, frame_data[DATA_BITS-1:1]};   // LSB arrives first.
        end
        if (state == RX_PARITY && bit_done) begin
            frame_parity <= rx_sync;
        end
        if (state == RX_STOP && bit_done) begin
            frame_stop <= rx_sync;
        end
    end

endmodule

/* hw/frame_checker.sv */
// Parity and stop bit checker
module frame_checker (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic                           frame_valid,
    input  logic [uart_pkg::DATA_BITS-1:0] frame_data,
    input  logic                           frame_parity,
    input  logic                           frame_stop,
    output logic                           byte_valid,
    output logic [uart_pkg::DATA_BITS-1:0] chk_byte,
    output logic                           chk_parity_err,
    output logic                           chk_frame_err
);

    logic parity_calc;
    logic parity_bad;
    logic stop_bad;

    // Even parity: data plus parity bit must hold an even number of ones.
    assign parity_calc = ^frame_data;
    assign parity_bad  = parity_calc ^ frame_parity;
    assign stop_bad    = ~frame_stop;   // A valid stop bit is high.

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            byte_valid     <= 1'b0;
            chk_parity_err <= 1'b0;
            chk_frame_err  <= 1'b0;
        end else begin
            byte_valid <= frame_valid;
            if (frame_valid) begin
                chk_parity_err <= parity_bad;
                chk_frame_err  <= stop_bad;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frame_valid) begin
            chk_byte <= frame_data;
        end
    end

endmodule

/* hw/rx_fifo.sv */
// Receive byte FIFO
module rx_fifo (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic                           byte_valid,
    input  logic [uart_pkg::DATA_BITS-1:0] chk_byte,
    input  logic                           chk_parity_err,
    input  logic                           chk_frame_err,
    input  logic                           rec_ready,
    output logic                           rx_ready,
    output logic [uart_pkg::DATA_BITS-1:0] rx_byte,
    output logic                           parity_err,
    output logic                           frame_err,
    output logic                           overflow
);

    import uart_pkg::*;

    logic [ENTRY_W-1:0] mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               push;
    logic               pop;
    logic [ENTRY_W-1:0] head;

    assign rx_ready = (count != '0);
    assign full     = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign pop      = rec_ready && rx_ready;   // Strobes on an empty FIFO are ignored.
    assign push     = byte_valid && (!full || pop);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (byte_valid && !push) begin
                overflow <= 1'b1;   // Sticky until reset.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= {chk_parity_err, chk_frame_err, chk_byte};
        end
    end

    // First-word fall-through, reading as zero while empty.
    assign head       = rx_ready ? mem[rd_ptr] : '0;
    assign rx_byte    = head[DATA_BITS-1:0];
    assign frame_err  = head[DATA_BITS];
    assign parity_err = head[DATA_BITS+1];

endmodule

/* hw/uart_rx_top.sv */
// UART receive path top
module uart_rx_top (
    input  logic                           clk,
    input  logic                           nRst,
    input  logic                           rx_serial,
    input  logic                           rec_ready,
    output logic                           rx_ready,
    output logic [uart_pkg::DATA_BITS-1:0] rx_byte,
    output logic                           parity_err,
    output logic                           frame_err,
    output logic                           overflow
);

    import uart_pkg::*;

    logic                 rx_sync;
    logic                 start_edge;
    logic                 frame_valid;
    logic [DATA_BITS-1:0] frame_data;
    logic                 frame_parity;
    logic                 frame_stop;
    logic                 byte_valid;
    logic [DATA_BITS-1:0] chk_byte;
    logic                 chk_parity_err;
    logic                 chk_frame_err;

    rx_line_sync u_sync (
        .clk        (clk),
        .nRst       (nRst),
        .rx_serial  (rx_serial),
        .rx_sync    (rx_sync),
        .start_edge (start_edge)
    );

    uart_rx u_rx (
        .clk          (clk),
        .nRst         (nRst),
        .rx_sync      (rx_sync),
        .start_edge   (start_edge),
        .frame_valid  (frame_valid),
        .frame_data   (frame_data),
        .frame_parity (frame_parity),
        .frame_stop   (frame_stop)
    );

    frame_checker u_chk (
        .clk            (clk),
        .nRst           (nRst),
        .frame_valid    (frame_valid),
        .frame_data     (frame_data),
        .frame_parity   (frame_parity),
        .frame_stop     (frame_stop),
        .byte_valid     (byte_valid),
        .chk_byte       (chk_byte),
        .chk_parity_err (chk_parity_err),
        .chk_frame_err  (chk_frame_err)
    );

    // The consumer strobe only pops, so the line is never stalled.
    rx_fifo u_fifo (
        .clk            (clk),
        .nRst           (nRst),
        .byte_valid     (byte_valid),
        .chk_byte       (chk_byte),
        .chk_parity_err (chk_parity_err),
        .chk_frame_err  (chk_frame_err),
        .rec_ready      (rec_ready),
        .rx_ready       (rx_ready),
        .rx_byte        (rx_byte),
        .parity_err     (parity_err),
        .frame_err      (frame_err),
        .overflow       (overflow)
    );

endmodule

/* sim/uart_rx_tb.sv */
// UART receive path testbench
module uart_rx_tb;

    import uart_pkg::*;

    localparam int NUM_ROWS    = 17;
    localparam int GLITCH_CLKS = HALF_BIT - 5;           // Below HALF_BIT - 3.
    localparam int WAIT_CLKS   = 4 * 11 * BIT_CLKS;      // Four frame times.
    localparam int QUIET_CLKS  = 12 * BIT_CLKS;          // One frame time plus margin.

    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic                 flip_par;
        logic                 stop;
        logic                 glitch;
        logic                 read_after;
    } row_t;

    logic                 clk;
    logic                 nRst;
    logic                 rx_serial;
    logic                 rec_ready;
    logic                 rx_ready;
    logic [DATA_BITS-1:0] rx_byte;
    logic                 parity_err;
    logic                 frame_err;
    logic                 overflow;

    row_t                 rows [NUM_ROWS];
    logic [ENTRY_W-1:0]   model_q [$];   // Entries are {parity_err, frame_err, byte}.
    logic                 exp_overflow;
    logic [31:0]          lfsr;

    uart_rx_top dut (
        .clk        (clk),
        .nRst       (nRst),
        .rx_serial  (rx_serial),
        .rec_ready  (rec_ready),
        .rx_ready   (rx_ready),
        .rx_byte    (rx_byte),
        .parity_err (parity_err),
        .frame_err  (frame_err),
        .overflow   (overflow)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_byte(output logic [DATA_BITS-1:0] b);
        for (int i = 0; i < DATA_BITS; i++) begin
            lfsr = lfsr_next(lfsr);
            b[i] = lfsr[0];   // One LFSR step per bit.
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s never happened", $time, what);
        $display("TEST FAILED");
        $fatal(1, "stopping after timeout");
    endtask

    task automatic set_row(input int i, input logic [DATA_BITS-1:0] data, input logic flip,
                           input logic stop, input logic glitch, input logic rd);
        rows[i] = {data, flip, stop, glitch, rd};
    endtask

    task automatic build_table();
        logic [DATA_BITS-1:0] r;
        set_row(0, 8'h00, 1'b0, 1'b1, 1'b0, 1'b1);
        set_row(1, 8'hFF, 1'b0, 1'b1, 1'b0, 1'b1);
        rand_byte(r);
        set_row(2, r, 1'b0, 1'b1, 1'b0, 1'b1);
        rand_byte(r);
        set_row(3, r, 1'b0, 1'b1, 1'b0, 1'b1);
        set_row(4, 8'hA5, 1'b1, 1'b1, 1'b0, 1'b1);   // Inverted parity bit.
        set_row(5, 8'h3C, 1'b0, 1'b1, 1'b0, 1'b1);
        set_row(6, 8'h5A, 1'b0, 1'b0, 1'b0, 1'b1);   // Stop bit low.
        set_row(7, 8'hC3, 1'b0, 1'b1, 1'b0, 1'b1);
        set_row(8, 8'h00, 1'b0, 1'b1, 1'b1, 1'b0);
        set_row(9, 8'h96, 1'b0, 1'b1, 1'b0, 1'b1);
        // Six frames without reads overrun the four-entry FIFO.
        for (int i = 10; i < 16; i++) begin
            rand_byte(r);
            set_row(i, r, 1'b0, 1'b1, 1'b0, i == 15);
        end
        set_row(16, 8'h81, 1'b0, 1'b1, 1'b0, 1'b1);
    endtask

    // Holds the line at one level for n clock cycles.
    task automatic drive_bit(input logic b, input int n);
        @(posedge clk);
        rx_serial <= b;
        repeat (n - 1) @(posedge clk);
    endtask

    task automatic send_frame(input row_t r);
        logic par;
        par = (^r.data) ^ r.flip_par;   // Even parity, optionally corrupted.
        drive_bit(1'b0, BIT_CLKS);
        for (int i = 0; i < DATA_BITS; i++) begin
            drive_bit(r.data[i], BIT_CLKS);
        end
        drive_bit(par, BIT_CLKS);
        drive_bit(r.stop, BIT_CLKS);
        drive_bit(1'b1, 2 * BIT_CLKS);
        if (model_q.size() < FIFO_DEPTH) begin
            model_q.push_back({r.flip_par, ~r.stop, r.data});
        end else begin
            exp_overflow = 1'b1;
        end
    endtask

    task automatic send_glitch();
        drive_bit(1'b0, GLITCH_CLKS);
        @(posedge clk);
        rx_serial <= 1'b1;
        // A glitch taken for a start bit would deliver a byte within one frame time.
        repeat (QUIET_CLKS) begin
            @(negedge clk);
            check_value("rx_ready", 1'b0, rx_ready);
        end
    endtask

    task automatic drain_expected();
        logic [ENTRY_W-1:0] exp;
        int                 t;
        while (model_q.size() > 0) begin
            exp = model_q.pop_front();
            t = 0;
            @(negedge clk);
            while (!rx_ready && t < WAIT_CLKS) begin
                t++;
                @(negedge clk);
            end
            if (!rx_ready) begin
                report_timeout("rx_ready for a received byte");
            end
            check_value("rx_byte", exp[DATA_BITS-1:0], rx_byte);
            check_value("frame_err", exp[DATA_BITS], frame_err);
            check_value("parity_err", exp[DATA_BITS+1], parity_err);
            check_value("overflow", exp_overflow, overflow);
            @(posedge clk);
            rec_ready <= 1'b1;
            @(posedge clk);
            rec_ready <= 1'b0;
        end
        @(negedge clk);
        check_value("rx_ready", 1'b0, rx_ready);   // Nothing beyond the model's entries.
    endtask

    initial begin
        clk          = 1'b0;
        nRst         = 1'b0;
        rx_serial    = 1'b1;
        rec_ready    = 1'b0;
        exp_overflow = 1'b0;
        lfsr         = 32'h505d;
        build_table();
        repeat (2) @(posedge clk);
        nRst <= 1'b1;

        // The idle line must leave the FIFO empty.
        repeat (3 * BIT_CLKS) begin
            @(negedge clk);
            check_value("rx_ready", 1'b0, rx_ready);
            check_value("overflow", 1'b0, overflow);
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            if (rows[i].glitch) begin
                send_glitch();
            end else begin
                send_frame(rows[i]);
            end
            if (rows[i].read_after) begin
                drain_expected();
            end
        end

        $display("TEST OK");
        $finish;
    end

endmodule

/* vlog.f */
hw/uart_pkg.sv
hw/rx_line_sync.sv
hw/uart_rx.sv
hw/frame_checker.sv
hw/rx_fifo.sv
hw/uart_rx_top.sv
sim/uart_rx_tb.sv
